//--- include/pwm_macros.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pwm peripheral constants
// widths, channel count and the
// AXI4-Lite register map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef PWM_MACROS_SVH
`define PWM_MACROS_SVH

// datapath sizing
`define PWM_CNT_W       16          // counter, period and compare width
`define PWM_NCH         4           // number of output channels

// bus sizing
`define PWM_ADDR_W      8           // axi4-lite byte address width

// register map, byte offsets
`define PWM_CTRL_OFS    8'h00       // bit 0 = enable
`define PWM_PERIOD_OFS  8'h04       // counter runs 0..period inclusive
`define PWM_CMP_OFS     8'h10       // channel n at base + 4n

`endif

//--- hw/pwm_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pwm shared types
// AXI4-Lite channel bundles and
// the live datapath configuration
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "pwm_macros.svh"

package pwm_pkg;

    localparam logic [1:0] axil_resp_okay = 2'b00;     // only response this slave gives

    typedef logic [`PWM_ADDR_W-1:0] axil_addr_t;

    // master to slave
    typedef struct packed {
        logic       aw_valid;
        axil_addr_t aw_addr;
        logic       w_valid;
        logic [31:0] w_data;
        logic [3:0] w_strb;                             // whole-word writes only
        logic       b_ready;
        logic       ar_valid;
        axil_addr_t ar_addr;
        logic       r_ready;
    } axil_req_t;

    // slave to master
    typedef struct packed {
        logic       aw_ready;
        logic       w_ready;
        logic       b_valid;
        logic [1:0] b_resp;
        logic       ar_ready;
        logic       r_valid;
        logic [31:0] r_data;
        logic [1:0] r_resp;
    } axil_rsp_t;

    // register block to timebase and channels
    typedef struct packed {
        logic                                enable;   // counter runs while set
        logic [`PWM_CNT_W-1:0]               period;   // last count before wrap
        logic [`PWM_NCH-1:0][`PWM_CNT_W-1:0] cmp;      // raw compare, not yet shadowed
    } pwm_cfg_t;

endpackage : pwm_pkg

//--- hw/pwm_axil_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pwm register block
// AXI4-Lite slave with control,
// period and compare registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "pwm_macros.svh"

module pwm_axil_regs
    import pwm_pkg::*;
(
    input  logic      pwm_clk,
    input  logic      pwm_resetn,
    input  axil_req_t axil_req,     // from bus master
    output axil_rsp_t axil_rsp,     // to bus master
    output pwm_cfg_t  cfg           // live configuration
);

    localparam int unsigned cnt_w  = `PWM_CNT_W;
    localparam int unsigned nch    = `PWM_NCH;
    localparam int unsigned addr_w = `PWM_ADDR_W;
    localparam int unsigned word_w = addr_w - 2;    // byte lane bits dropped

    localparam axil_addr_t ctrl_addr   = `PWM_CTRL_OFS;
    localparam axil_addr_t period_addr = `PWM_PERIOD_OFS;
    localparam axil_addr_t cmp_addr    = `PWM_CMP_OFS;

    logic [word_w-1:0] aw_word;     // write word offset
    logic [word_w-1:0] ar_word;     // read word offset
    logic              wr_fire;     // aw and w handshake together
    logic              rd_fire;     // ar handshake
    logic              ctrl_we;
    logic              period_we;
    logic [nch-1:0]    cmp_we;      // one strobe per channel
    logic              b_pend;      // write response outstanding
    logic              r_pend;      // read response outstanding
    logic [31:0]       rd_word;     // read mux result
    logic [31:0]       r_data_q;    // held read data

    assign aw_word = axil_req.aw_addr[addr_w-1:2];
    assign ar_word = axil_req.ar_addr[addr_w-1:2];

    assign wr_fire = axil_req.aw_valid && axil_req.w_valid && !b_pend;
    assign rd_fire = axil_req.ar_valid && !r_pend;

    // write decode, unmapped offsets get no strobe
    always_comb
    begin
        ctrl_we   = wr_fire && (aw_word == ctrl_addr[addr_w-1:2]);
        period_we = wr_fire && (aw_word == period_addr[addr_w-1:2]);
        for (int i = 0; i < nch; i++)
        begin
            cmp_we[i] = wr_fire && (aw_word == cmp_addr[addr_w-1:2] + word_w'(i));
        end
    end

    // read mux
    always_comb
    begin
        rd_word = '0;                                       // unmapped reads zero
        if (ar_word == ctrl_addr[addr_w-1:2])
            rd_word = 32'(cfg.enable);
        if (ar_word == period_addr[addr_w-1:2])
            rd_word = 32'(cfg.period);
        for (int i = 0; i < nch; i++)
        begin
            if (ar_word == cmp_addr[addr_w-1:2] + word_w'(i))
                rd_word = 32'(cfg.cmp[i]);
        end
    end

    // configuration registers, updated on the handshake edge
    always_ff @(posedge pwm_clk or negedge pwm_resetn)
    begin
        if (!pwm_resetn)
        begin
            cfg <= '0;
        end
        else
        begin
            if (ctrl_we)
                cfg.enable <= axil_req.w_data[0];           // other bits ignored
            if (period_we)
                cfg.period <= axil_req.w_data[cnt_w-1:0];
            for (int i = 0; i < nch; i++)
            begin
                if (cmp_we[i])
                    cfg.cmp[i] <= axil_req.w_data[cnt_w-1:0];
            end
        end
    end

    // response channels
    always_ff @(posedge pwm_clk or negedge pwm_resetn)
    begin
        if (!pwm_resetn)
        begin
            b_pend   <= 1'b0;
            r_pend   <= 1'b0;
            r_data_q <= '0;
        end
        else
        begin
            if (wr_fire)
                b_pend <= 1'b1;                             // response next cycle
            else if (axil_req.b_ready)
                b_pend <= 1'b0;
            if (rd_fire)
            begin
                r_pend   <= 1'b1;
                r_data_q <= rd_word;                        // captured at the handshake
            end
            else if (axil_req.r_ready)
            begin
                r_pend <= 1'b0;
            end
        end
    end

    // aw and w accepted as a pair; high when idle, low when only one side is valid
    assign axil_rsp.aw_ready = !b_pend && (axil_req.aw_valid == axil_req.w_valid);
    assign axil_rsp.w_ready  = !b_pend && (axil_req.aw_valid == axil_req.w_valid);
    assign axil_rsp.b_valid  = b_pend;
    assign axil_rsp.b_resp   = axil_resp_okay;
    assign axil_rsp.ar_ready = !r_pend;
    assign axil_rsp.r_valid  = r_pend;
    assign axil_rsp.r_data   = r_data_q;
    assign axil_rsp.r_resp   = axil_resp_okay;

    b_hold: assert property (@(posedge pwm_clk) disable iff (!pwm_resetn)
        axil_rsp.b_valid && !axil_req.b_ready |=> axil_rsp.b_valid);

    r_stable: assert property (@(posedge pwm_clk) disable iff (!pwm_resetn)
        axil_rsp.r_valid && !axil_req.r_ready |=> $stable(axil_rsp.r_data));

endmodule : pwm_axil_regs

//--- hw/pwm_timebase.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pwm timebase
// shared up-counter wrapping at
// the programmed period
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "pwm_macros.svh"

module pwm_timebase
    import pwm_pkg::*;
(
    input  logic                  pwm_clk,
    input  logic                  pwm_resetn,
    input  pwm_cfg_t              cfg,      // enable and period used here
    output logic [`PWM_CNT_W-1:0] count,    // shared count
    output logic                  wrap      // last cycle of the period
);

    logic at_end;   // equals period in steady state

    // at or above catches a period lowered below the running count
    assign at_end = (count >= cfg.period);
    assign wrap   = cfg.enable && at_end;

    always_ff @(posedge pwm_clk or negedge pwm_resetn)
    begin
        if (!pwm_resetn)
            count <= '0;
        else if (!cfg.enable)
            count <= '0;            // parked while disabled
        else if (at_end)
            count <= '0;            // wrap
        else
            count <= count + 1'b1;
    end

    cnt_in_range: assert property (@(posedge pwm_clk) disable iff (!pwm_resetn)
        cfg.enable && $stable(cfg.period) |-> count <= cfg.period);

    wrap_restarts: assert property (@(posedge pwm_clk) disable iff (!pwm_resetn)
        wrap |-> cfg.enable ##1 (count == '0));

endmodule : pwm_timebase

//--- hw/pwm_channel.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pwm channel
// shadowed compare and registered
// output comparator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "pwm_macros.svh"

module pwm_channel
(
    input  logic                  pwm_clk,
    input  logic                  pwm_resetn,
    input  logic                  enable,   // block enable
    input  logic [`PWM_CNT_W-1:0] cmp,      // compare from register block
    input  logic [`PWM_CNT_W-1:0] count,    // shared timebase count
    input  logic                  wrap,     // period boundary
    output logic                  pwm_out
);

    logic [`PWM_CNT_W-1:0] cmp_shadow;  // value the comparator sees

    always_ff @(posedge pwm_clk or negedge pwm_resetn)
    begin
        if (!pwm_resetn)
        begin
            cmp_shadow <= '0;
            pwm_out    <= 1'b0;
        end
        else
        begin
            // new compare only at a period boundary, or at once when idle
            if (wrap || !enable)
                cmp_shadow <= cmp;
            pwm_out <= enable && (count >= cmp_shadow);     // one cycle behind count
        end
    end

    out_low_when_off: assert property (@(posedge pwm_clk) disable iff (!pwm_resetn)
        !enable |=> !pwm_out);

endmodule : pwm_channel

//--- hw/pwm_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pwm peripheral top
// register block, timebase and
// the channel array
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "pwm_macros.svh"

module pwm_top
    import pwm_pkg::*;
(
    input  logic                pwm_clk,
    input  logic                pwm_resetn,
    input  axil_req_t           axil_req,
    output axil_rsp_t           axil_rsp,
    output logic [`PWM_NCH-1:0] pwm_out     // one bit per channel
);

    pwm_cfg_t              cfg;     // live configuration
    logic [`PWM_CNT_W-1:0] count;   // shared count
    logic                  wrap;    // period boundary

    pwm_axil_regs u_regs (
        .pwm_clk    (pwm_clk),
        .pwm_resetn (pwm_resetn),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .cfg        (cfg)
    );

    pwm_timebase u_timebase (
        .pwm_clk    (pwm_clk),
        .pwm_resetn (pwm_resetn),
        .cfg        (cfg),
        .count      (count),
        .wrap       (wrap)
    );

    for (genvar ch = 0; ch < `PWM_NCH; ch++)
    begin : g_ch
        pwm_channel u_channel (
            .pwm_clk    (pwm_clk),
            .pwm_resetn (pwm_resetn),
            .enable     (cfg.enable),
            .cmp        (cfg.cmp[ch]),      // own compare slot
            .count      (count),
            .wrap       (wrap),
            .pwm_out    (pwm_out[ch])
        );
    end

endmodule : pwm_top

//--- tb/pwm_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pwm peripheral testbench
// trace-driven AXI4-Lite accesses,
// readback and duty measurement
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "pwm_macros.svh"

module pwm_tb
    import pwm_pkg::*;
();

    logic                pwm_clk;
    logic                pwm_resetn;
    axil_req_t           axil_req;
    axil_rsp_t           axil_rsp;
    logic [`PWM_NCH-1:0] pwm_out;

    byte         op_q[$];           // trace opcode per command
    logic [31:0] arg_a_q[$];        // address or channel
    logic [31:0] arg_b_q[$];        // data or expected value
    int unsigned max_period;        // largest period in the trace
    int unsigned cur_period;        // period last written
    bit          trace_loaded;

    pwm_top dut (
        .pwm_clk    (pwm_clk),
        .pwm_resetn (pwm_resetn),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .pwm_out    (pwm_out)
    );

    always #10 pwm_clk = ~pwm_clk;      // 20 ns period

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic load_trace();
        int          fd;
        int          n;
        string       line;
        byte         op;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("tb/pwm_trace.txt", "r");
        if (fd == 0)
            fail_run("could not open the trace file tb/pwm_trace.txt");
        while ($fgets(line, fd) != 0)
        begin
            n = $sscanf(line, "%c %h %h", op, a, b);
            if (op == "#")
                continue;                                   // column notes
            if (n != 3 || (op != "W" && op != "R" && op != "D"))
                fail_run({"malformed trace line: ", line});
            op_q.push_back(op);
            arg_a_q.push_back(a);
            arg_b_q.push_back(b);
            if (op == "W" && a[`PWM_ADDR_W-1:0] == `PWM_PERIOD_OFS && b > max_period)
                max_period = b;
        end
        $fclose(fd);
    endtask

    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data);
        int stall;
        @(negedge pwm_clk);
        axil_req.aw_valid = 1'b1;
        axil_req.w_valid  = 1'b1;
        axil_req.aw_addr  = addr[`PWM_ADDR_W-1:0];
        axil_req.w_data   = data;
        axil_req.w_strb   = 4'hf;
        #1;                                                 // ready settles after valid
        while (!(axil_rsp.aw_ready && axil_rsp.w_ready))
        begin
            @(negedge pwm_clk);
            #1;
        end
        @(negedge pwm_clk);                                 // handshake took the posedge
        axil_req.aw_valid = 1'b0;
        axil_req.w_valid  = 1'b0;
        while (!axil_rsp.b_valid)
            @(negedge pwm_clk);
        stall = $urandom % 4;
        repeat (stall) @(negedge pwm_clk);                  // b_ready back-pressure
        assert (axil_rsp.b_valid)
        else fail_run("write response was dropped while b_ready was held low");
        assert (axil_rsp.b_resp == axil_resp_okay)
        else fail_run($sformatf("MISMATCH at %0t: write to %h got bresp %b",
                                $time, addr, axil_rsp.b_resp));
        axil_req.b_ready = 1'b1;
        @(negedge pwm_clk);
        axil_req.b_ready = 1'b0;
        assert (!axil_rsp.b_valid)
        else fail_run("write response was still valid after it was accepted");
        if (addr[`PWM_ADDR_W-1:0] == `PWM_PERIOD_OFS)
            cur_period = data[`PWM_CNT_W-1:0];              // duty window follows it
    endtask

    task automatic axil_read(input logic [31:0] addr, input logic [31:0] expect_data);
        int          stall;
        logic [31:0] got;
        @(negedge pwm_clk);
        axil_req.ar_valid = 1'b1;
        axil_req.ar_addr  = addr[`PWM_ADDR_W-1:0];
        #1;
        while (!axil_rsp.ar_ready)
        begin
            @(negedge pwm_clk);
            #1;
        end
        @(negedge pwm_clk);
        axil_req.ar_valid = 1'b0;
        while (!axil_rsp.r_valid)
            @(negedge pwm_clk);
        stall = $urandom % 4;
        repeat (stall) @(negedge pwm_clk);                  // r_ready back-pressure
        assert (axil_rsp.r_valid)
        else fail_run("read response was dropped while r_ready was held low");
        got = axil_rsp.r_data;
        assert (got == expect_data && axil_rsp.r_resp == axil_resp_okay)
        else fail_run($sformatf("MISMATCH at %0t: read %h gave %h resp %b, expected %h",
                                $time, addr, got, axil_rsp.r_resp, expect_data));
        axil_req.r_ready = 1'b1;
        @(negedge pwm_clk);
        axil_req.r_ready = 1'b0;
        assert (!axil_rsp.r_valid)
        else fail_run("read response was still valid after it was accepted");
    endtask

    task automatic measure_duty(input int ch, input int expect_high);
        int high;
        repeat (2 * (cur_period + 1)) @(negedge pwm_clk);  // let a shadow update land
        high = 0;
        repeat (cur_period + 1)
        begin
            @(negedge pwm_clk);
            if (pwm_out[ch])
                high++;
        end
        assert (high == expect_high)
        else fail_run($sformatf("MISMATCH at %0t: channel %0d high %0d of %0d, expected %0d",
                                $time, ch, high, cur_period + 1, expect_high));
    endtask

    initial
    begin
        void'($urandom(32'hc2be_ea8f));                     // one seed for the whole run
        pwm_clk      = 1'b0;
        pwm_resetn   = 1'b0;
        axil_req     = '0;
        max_period   = 0;
        cur_period   = 0;
        trace_loaded = 1'b0;
        load_trace();
        trace_loaded = 1'b1;
        repeat (4) @(negedge pwm_clk);
        pwm_resetn = 1'b1;
        for (int i = 0; i < op_q.size(); i++)
        begin
            case (op_q[i])
                "W":     axil_write(arg_a_q[i], arg_b_q[i]);
                "R":     axil_read(arg_a_q[i], arg_b_q[i]);
                default: measure_duty(arg_a_q[i], arg_b_q[i]);
            endcase
        end
        $display("TESTS PASSED");
        $finish;
    end

    initial
    begin : watchdog
        int unsigned limit;
        wait (trace_loaded);
        limit = op_q.size() * (4 * (max_period + 1) + 50);  // per command budget
        repeat (limit) @(posedge pwm_clk);
        fail_run($sformatf("watchdog expired after %0d cycles, the run hung", limit));
    end

endmodule : pwm_tb

//--- tb/pwm_trace.txt
# op addr data : W write, R read and compare (addr, expected data), all hex
# op chan expect : D duty check, high cycles over one period, all hex
R 00 00000000   # registers are zero after reset
R 04 00000000
R 10 00000000
R 1c 00000000
W 04 00000009   # period 9, ten-cycle window
W 10 00000000
W 14 00000003
W 18 00000007
W 1c 0000000a
R 04 00000009
R 10 00000000
R 14 00000003
R 18 00000007
R 1c 0000000a
W 20 0000beef   # unmapped, dropped
R 20 00000000
R 08 00000000
W 00 00000001   # enable
R 00 00000001
D 00 0000000a
D 01 00000007
D 02 00000003
D 03 00000000
W 14 00000005   # compare change while running
D 01 00000005
D 00 0000000a
W 00 00000000   # disable
D 00 00000000
D 01 00000000
D 02 00000000
W 00 00000001
W 04 00000003   # period 3, four-cycle window
W 18 00000002
D 02 00000002
D 00 00000004
D 01 00000000
D 03 00000000
R 04 00000003
R 18 00000002
R 14 00000005

//--- pwm_top.f
+incdir+include
hw/pwm_pkg.sv
hw/pwm_axil_regs.sv
hw/pwm_timebase.sv
hw/pwm_channel.sv
hw/pwm_top.sv
tb/pwm_tb.sv

//--- Bender.yml
package:
  name: pwm_top

export_include_dirs:
  - include

sources:
  - hw/pwm_pkg.sv
  - hw/pwm_axil_regs.sv
  - hw/pwm_timebase.sv
  - hw/pwm_channel.sv
  - hw/pwm_top.sv
  - target: test
    files:
      - tb/pwm_tb.sv
